// ==== verilog.f ====
hdl/rvv_cfg_pkg.sv
hdl/rvv_uop_pkg.sv
hdl/rvv_pu2rob_if.sv
hdl/rvv_alu_issue_queue.sv
hdl/rvv_alu_mask_unit.sv
hdl/rvv_alu_result_stage.sv
hdl/rvv_alu_top.sv
test/tb_rvv_alu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f verilog.f --top-module tb_rvv_alu_top -o sim_tb

output="$(./obj_dir/sim_tb)"
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi

// ==== test/tb_rvv_alu_top.sv ====
`default_nettype none

module tb_rvv_alu_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int vlen = rvv_cfg_pkg::vlen;
  localparam int push_timeout = 500;
  localparam int drain_timeout = 1000;
  localparam int idle_timeout = 200;

  // operand patterns that the expected results below are worked out from
  localparam logic [vlen-1:0] vs2_pat = 128'hFFFF0000_F0F0F0F0_CCCCCCCC_AAAAAAAA;
  localparam logic [vlen-1:0] vs1_pat = 128'hFF00FF00_FF00FF00_F0F0F0F0_CCCCCCCC;
  localparam logic [vlen-1:0] vd_pat = {4{32'h5A5A5A5A}};

  typedef struct {
    logic [2:0]      funct3;
    logic [5:0]      funct6;
    logic [1:0]      eew;
    logic [6:0]      vstart;
    logic            vm;
    logic [vlen-1:0] vd;
    logic            vd_v;
    logic            vs1_v;
    logic            vs2_v;
    logic [31:0]     rs1;
    logic            rs1_v;
    logic            expect_res;
    logic [vlen-1:0] exp_data;
    logic            exp_vta;
  } row_t;

  logic            clk;
  logic            reset;
  logic            uop_valid;
  logic            uop_ready;
  logic [3:0]      uop_rob_entry;
  logic [5:0]      uop_funct6;
  logic [2:0]      uop_funct3;
  logic [6:0]      uop_vstart;
  logic            uop_vm;
  logic [vlen-1:0] uop_vd_data;
  logic            uop_vd_data_valid;
  logic [vlen-1:0] uop_vs1_data;
  logic            uop_vs1_data_valid;
  logic [vlen-1:0] uop_vs2_data;
  logic            uop_vs2_data_valid;
  logic [1:0]      uop_vs2_eew;
  logic [31:0]     uop_rs1_data;
  logic            uop_rs1_data_valid;
  logic            result_valid;
  logic            result_ready;
  logic [3:0]      result_rob_entry;
  logic [vlen-1:0] result_w_data;
  logic            result_vxsat;
  logic            result_ignore_vta;
  logic            result_ignore_vma;

  row_t   rows[$];
  int     expected[$];
  int     errors = 0;
  int     checked = 0;
  int     dropped = 0;
  int     next_seq = 0;
  logic   bp_phase = 1'b0;
  logic   saw_full = 1'b0;
  logic   stop = 1'b0;
  integer seed = 32'hcedf5f60;

  rvv_alu_top #(
    .queue_depth (4)
  ) rvv_alu_top_i (
    .clk                (clk),
    .reset              (reset),
    .uop_valid          (uop_valid),
    .uop_ready          (uop_ready),
    .uop_rob_entry      (uop_rob_entry),
    .uop_funct6         (uop_funct6),
    .uop_funct3         (uop_funct3),
    .uop_vstart         (uop_vstart),
    .uop_vm             (uop_vm),
    .uop_vd_data        (uop_vd_data),
    .uop_vd_data_valid  (uop_vd_data_valid),
    .uop_vs1_data       (uop_vs1_data),
    .uop_vs1_data_valid (uop_vs1_data_valid),
    .uop_vs2_data       (uop_vs2_data),
    .uop_vs2_data_valid (uop_vs2_data_valid),
    .uop_vs2_eew        (uop_vs2_eew),
    .uop_rs1_data       (uop_rs1_data),
    .uop_rs1_data_valid (uop_rs1_data_valid),
    .result_valid       (result_valid),
    .result_ready       (result_ready),
    .result_rob_entry   (result_rob_entry),
    .result_w_data      (result_w_data),
    .result_vxsat       (result_vxsat),
    .result_ignore_vta  (result_ignore_vta),
    .result_ignore_vma  (result_ignore_vma)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic row_t default_row();
    row_t r;
    r.funct3 = rvv_uop_pkg::opivv;
    r.funct6 = 6'b000000;
    r.eew = rvv_uop_pkg::eew32;
    r.vstart = 7'd0;
    r.vm = 1'b1;
    r.vd = vd_pat;
    r.vd_v = 1'b1;
    r.vs1_v = 1'b1;
    r.vs2_v = 1'b1;
    r.rs1 = 32'h0;
    r.rs1_v = 1'b1;
    r.expect_res = 1'b1;
    r.exp_data = '0;
    r.exp_vta = 1'b0;
    return r;
  endfunction

  task automatic add_vector_row(input logic [5:0] funct6, input logic [vlen-1:0] exp_data);
    row_t r;
    r = default_row();
    r.funct6 = funct6;
    r.exp_data = exp_data;
    rows.push_back(r);
  endtask

  // scalar forms run with vs1 marked invalid
  task automatic add_scalar_row(input logic [2:0] funct3, input logic [5:0] funct6,
                                input logic [1:0] eew, input logic [31:0] rs1,
                                input logic [vlen-1:0] exp_data);
    row_t r;
    r = default_row();
    r.funct3 = funct3;
    r.funct6 = funct6;
    r.eew = eew;
    r.rs1 = rs1;
    r.vs1_v = 1'b0;
    r.exp_data = exp_data;
    rows.push_back(r);
  endtask

  task automatic add_mask_row(input logic [5:0] funct6, input logic [6:0] vstart,
                              input logic [vlen-1:0] vd, input logic [vlen-1:0] exp_data);
    row_t r;
    r = default_row();
    r.funct3 = rvv_uop_pkg::opmvv;
    r.funct6 = funct6;
    r.vstart = vstart;
    r.vd = vd;
    r.exp_data = exp_data;
    r.exp_vta = 1'b1;
    rows.push_back(r);
  endtask

  task automatic add_drop_row(input logic [2:0] funct3, input logic [5:0] funct6,
                              input logic vm, input logic vd_v, input logic vs1_v,
                              input logic rs1_v);
    row_t r;
    r = default_row();
    r.funct3 = funct3;
    r.funct6 = funct6;
    r.vm = vm;
    r.vd_v = vd_v;
    r.vs1_v = vs1_v;
    r.rs1_v = rs1_v;
    r.expect_res = 1'b0;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_vector_row(rvv_uop_pkg::vand, 128'hFF000000_F000F000_C0C0C0C0_88888888);
    add_vector_row(rvv_uop_pkg::vor, 128'hFFFFFF00_FFF0FFF0_FCFCFCFC_EEEEEEEE);
    add_vector_row(rvv_uop_pkg::vxor, 128'h00FFFF00_0FF00FF0_3C3C3C3C_66666666);
    add_scalar_row(rvv_uop_pkg::opivx, rvv_uop_pkg::vand, rvv_uop_pkg::eew8,
                   32'h12345678, 128'h78780000_70707070_48484848_28282828);
    add_scalar_row(rvv_uop_pkg::opivi, rvv_uop_pkg::vxor, rvv_uop_pkg::eew8,
                   32'hABCDEF0F, 128'hF0F00F0F_FFFFFFFF_C3C3C3C3_A5A5A5A5);
    add_scalar_row(rvv_uop_pkg::opivi, rvv_uop_pkg::vor, rvv_uop_pkg::eew16,
                   32'h12345678, 128'hFFFF5678_F6F8F6F8_DEFCDEFC_FEFAFEFA);
    add_scalar_row(rvv_uop_pkg::opivx, rvv_uop_pkg::vand, rvv_uop_pkg::eew16,
                   32'hFFFF00FF, 128'h00FF0000_00F000F0_00CC00CC_00AA00AA);
    add_scalar_row(rvv_uop_pkg::opivx, rvv_uop_pkg::vxor, rvv_uop_pkg::eew32,
                   32'h12345678, 128'hEDCB5678_E2C4A688_DEF89AB4_B89EFCD2);
    add_scalar_row(rvv_uop_pkg::opivi, rvv_uop_pkg::vand, rvv_uop_pkg::eew32,
                   32'h0F0FF0F0, 128'h0F0F0000_0000F0F0_0C0CC0C0_0A0AA0A0);
    // unsupported encodings followed by missing operands and vm clear
    add_drop_row(rvv_uop_pkg::opivv, 6'b000000, 1'b1, 1'b1, 1'b1, 1'b1);
    add_drop_row(rvv_uop_pkg::opmvv, 6'b001001, 1'b1, 1'b1, 1'b1, 1'b1);
    add_drop_row(3'b001, rvv_uop_pkg::vand, 1'b1, 1'b1, 1'b1, 1'b1);
    add_drop_row(rvv_uop_pkg::opivv, rvv_uop_pkg::vand, 1'b1, 1'b1, 1'b0, 1'b1);
    add_drop_row(rvv_uop_pkg::opivx, rvv_uop_pkg::vor, 1'b1, 1'b1, 1'b1, 1'b0);
    add_drop_row(rvv_uop_pkg::opmvv, rvv_uop_pkg::vmand, 1'b1, 1'b0, 1'b1, 1'b1);
    add_drop_row(rvv_uop_pkg::opmvv, rvv_uop_pkg::vmand, 1'b0, 1'b1, 1'b1, 1'b1);
    add_mask_row(rvv_uop_pkg::vmandn, 7'd0, vd_pat, 128'h00FF0000_00F000F0_0C0C0C0C_22222222);
    add_mask_row(rvv_uop_pkg::vmand, 7'd0, vd_pat, 128'hFF000000_F000F000_C0C0C0C0_88888888);
    add_mask_row(rvv_uop_pkg::vmor, 7'd0, vd_pat, 128'hFFFFFF00_FFF0FFF0_FCFCFCFC_EEEEEEEE);
    add_mask_row(rvv_uop_pkg::vmxor, 7'd0, vd_pat, 128'h00FFFF00_0FF00FF0_3C3C3C3C_66666666);
    add_mask_row(rvv_uop_pkg::vmorn, 7'd0, vd_pat, 128'hFFFF00FF_F0FFF0FF_CFCFCFCF_BBBBBBBB);
    add_mask_row(rvv_uop_pkg::vmnand, 7'd0, vd_pat, 128'h00FFFFFF_0FFF0FFF_3F3F3F3F_77777777);
    add_mask_row(rvv_uop_pkg::vmnor, 7'd0, vd_pat, 128'h000000FF_000F000F_03030303_11111111);
    add_mask_row(rvv_uop_pkg::vmxnor, 7'd0, vd_pat, 128'hFF0000FF_F00FF00F_C3C3C3C3_99999999);
    // vd kept below vstart
    add_mask_row(rvv_uop_pkg::vmandn, 7'd1, {vlen{1'b1}},
                 128'h00FF0000_00F000F0_0C0C0C0C_22222223);
    add_mask_row(rvv_uop_pkg::vmand, 7'd37, vd_pat, 128'hFF000000_F000F000_C0C0C0DA_5A5A5A5A);
    add_mask_row(rvv_uop_pkg::vmor, 7'd64, vd_pat, 128'hFFFFFF00_FFF0FFF0_5A5A5A5A_5A5A5A5A);
    add_mask_row(rvv_uop_pkg::vmxnor, 7'd127, vd_pat, 128'hDA5A5A5A_5A5A5A5A_5A5A5A5A_5A5A5A5A);
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while %s, next row seq %0d", what, next_seq);
    $display("checked %0d, dropped %0d, errors %0d", checked, dropped, errors + 1);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic push_row(input int seq);
    row_t r;
    int   waited;
    logic accepted;
    r = rows[seq % rows.size()];
    uop_rob_entry = seq[3:0];
    uop_funct6 = r.funct6;
    uop_funct3 = r.funct3;
    uop_vstart = r.vstart;
    uop_vm = r.vm;
    uop_vd_data = r.vd;
    uop_vd_data_valid = r.vd_v;
    uop_vs1_data = vs1_pat;
    uop_vs1_data_valid = r.vs1_v;
    uop_vs2_data = vs2_pat;
    uop_vs2_data_valid = r.vs2_v;
    uop_vs2_eew = r.eew;
    uop_rs1_data = r.rs1;
    uop_rs1_data_valid = r.rs1_v;
    uop_valid = 1'b1;
    if (r.expect_res) begin
      expected.push_back(seq);
    end
    waited = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (uop_ready) begin
        accepted = 1'b1;
      end else begin
        waited++;
        if (waited > push_timeout) begin
          timeout_fail("waiting for uop_ready");
        end
      end
    end
    @(posedge clk);
    #2;
  endtask

  // rows skipped by the collector produced no result
  task automatic report_dropped(input int upto);
    for (int k = next_seq; k < upto; k++) begin
      $display("row %0d seq %0d: no result, dropped as expected", k % rows.size(), k);
      dropped++;
    end
  endtask

  task automatic check_result(input int seq);
    row_t r;
    int   errs_before;
    r = rows[seq % rows.size()];
    errs_before = errors;
    if (result_rob_entry !== seq[3:0]) begin
      $display("Mismatch result_rob_entry seq %0d: got %h, expected %h",
               seq, result_rob_entry, seq[3:0]);
      errors++;
    end
    if (result_w_data !== r.exp_data) begin
      $display("Mismatch result_w_data seq %0d: got %h, expected %h",
               seq, result_w_data, r.exp_data);
      errors++;
    end
    if (result_vxsat !== 1'b0) begin
      $display("Mismatch result_vxsat seq %0d: got %h, expected 0", seq, result_vxsat);
      errors++;
    end
    if (result_ignore_vta !== r.exp_vta) begin
      $display("Mismatch result_ignore_vta seq %0d: got %h, expected %h",
               seq, result_ignore_vta, r.exp_vta);
      errors++;
    end
    if (result_ignore_vma !== 1'b0) begin
      $display("Mismatch result_ignore_vma seq %0d: got %h, expected 0", seq, result_ignore_vma);
      errors++;
    end
    checked++;
    if (errors == errs_before) begin
      $display("row %0d seq %0d: pass", seq % rows.size(), seq);
    end else begin
      $display("row %0d seq %0d: FAILED", seq % rows.size(), seq);
    end
  endtask

  // random ready only in the back-pressure phase
  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk);
      #2;
      r = $random(seed);
      result_ready = bp_phase ? (r[2:0] < 3'd3) : 1'b1;
    end
  end

  // collector samples at the falling edge where everything has settled
  initial begin
    int              idle;
    int              s;
    logic            held_valid;
    logic [3:0]      held_entry;
    logic [vlen-1:0] held_data;
    logic [2:0]      held_flags;
    idle = 0;
    held_valid = 1'b0;
    while (!stop) begin
      @(negedge clk);
      if (!reset) begin
        if (held_valid) begin
          if (!result_valid) begin
            $display("result_valid fell while a result was held by back-pressure");
            errors++;
          end else if (result_rob_entry !== held_entry) begin
            $display("Mismatch held result_rob_entry: got %h, expected %h",
                     result_rob_entry, held_entry);
            errors++;
          end else if (result_w_data !== held_data) begin
            $display("Mismatch held result_w_data: got %h, expected %h", result_w_data, held_data);
            errors++;
          end else if ({result_vxsat, result_ignore_vta, result_ignore_vma} !== held_flags) begin
            $display("Mismatch held result flags: got %h, expected %h",
                     {result_vxsat, result_ignore_vta, result_ignore_vma}, held_flags);
            errors++;
          end
        end
        if (bp_phase && !uop_ready) begin
          saw_full = 1'b1;
        end
        if (result_valid && result_ready) begin
          idle = 0;
          if (expected.size() == 0) begin
            $display("Unexpected result with rob_entry %h while no row was waiting",
                     result_rob_entry);
            errors++;
          end else begin
            s = expected.pop_front();
            report_dropped(s);
            check_result(s);
            next_seq = s + 1;
          end
        end else if (expected.size() != 0) begin
          idle++;
          if (idle > idle_timeout) begin
            timeout_fail("waiting for result_valid");
          end
        end
        held_valid = result_valid && !result_ready;
        held_entry = result_rob_entry;
        held_data = result_w_data;
        held_flags = {result_vxsat, result_ignore_vta, result_ignore_vma};
      end
    end
  end

  initial begin
    int waited;
    int total;
    reset = 1'b1;
    uop_valid = 1'b0;
    uop_rob_entry = '0;
    uop_funct6 = '0;
    uop_funct3 = '0;
    uop_vstart = '0;
    uop_vm = 1'b0;
    uop_vd_data = '0;
    uop_vd_data_valid = 1'b0;
    uop_vs1_data = '0;
    uop_vs1_data_valid = 1'b0;
    uop_vs2_data = '0;
    uop_vs2_data_valid = 1'b0;
    uop_vs2_eew = '0;
    uop_rs1_data = '0;
    uop_rs1_data_valid = 1'b0;
    result_ready = 1'b1;
    build_table();
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    if (uop_ready !== 1'b1 || result_valid !== 1'b0) begin
      $display("after reset uop_ready is not high or result_valid is not low");
      errors++;
    end
    @(posedge clk);
    #2;
    // second pass repeats the table under random back-pressure
    for (int pass = 0; pass < 2; pass++) begin
      bp_phase = (pass == 1);
      for (int i = 0; i < rows.size(); i++) begin
        push_row(pass * rows.size() + i);
      end
    end
    uop_valid = 1'b0;
    waited = 0;
    while (expected.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > drain_timeout) begin
        timeout_fail("draining results");
      end
    end
    // window for stray results
    repeat (10) @(negedge clk);
    @(posedge clk);
    stop = 1'b1;
    @(negedge clk);
    #1;
    total = 2 * rows.size();
    report_dropped(total);
    if (!saw_full) begin
      $display("uop_ready never fell during the back-pressure phase");
      errors++;
    end
    $display("checked %0d, dropped %0d, errors %0d", checked, dropped, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/rvv_alu_top.sv ====
`default_nettype none

module rvv_alu_top #(
  parameter int queue_depth = 4
) (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    uop_valid,
  output logic                                    uop_ready,
  input  logic [rvv_cfg_pkg::rob_depth_width-1:0] uop_rob_entry,
  input  logic [rvv_uop_pkg::funct6_width-1:0]    uop_funct6,
  input  logic [rvv_uop_pkg::funct3_width-1:0]    uop_funct3,
  input  logic [rvv_cfg_pkg::vstart_width-1:0]    uop_vstart,
  input  logic                                    uop_vm,
  input  logic [rvv_cfg_pkg::vlen-1:0]            uop_vd_data,
  input  logic                                    uop_vd_data_valid,
  input  logic [rvv_cfg_pkg::vlen-1:0]            uop_vs1_data,
  input  logic                                    uop_vs1_data_valid,
  input  logic [rvv_cfg_pkg::vlen-1:0]            uop_vs2_data,
  input  logic                                    uop_vs2_data_valid,
  input  logic [1:0]                              uop_vs2_eew,
  input  logic [rvv_cfg_pkg::xlen-1:0]            uop_rs1_data,
  input  logic                                    uop_rs1_data_valid,
  output logic                                    result_valid,
  input  logic                                    result_ready,
  output logic [rvv_cfg_pkg::rob_depth_width-1:0] result_rob_entry,
  output logic [rvv_cfg_pkg::vlen-1:0]            result_w_data,
  output logic                                    result_vxsat,
  output logic                                    result_ignore_vta,
  output logic                                    result_ignore_vma
);

  rvv_uop_pkg::alu_rs_t in_uop;
  rvv_uop_pkg::alu_rs_t rs_uop;
  logic                 rs_valid;
  logic                 rs_ready;
  rvv_uop_pkg::pu2rob_t out_rec;

  assign in_uop.rob_entry      = uop_rob_entry;
  assign in_uop.funct6         = uop_funct6;
  assign in_uop.funct3         = rvv_uop_pkg::funct3_e'(uop_funct3);
  assign in_uop.vstart         = uop_vstart;
  assign in_uop.vm             = uop_vm;
  assign in_uop.vd_data        = uop_vd_data;
  assign in_uop.vd_data_valid  = uop_vd_data_valid;
  assign in_uop.vs1_data       = uop_vs1_data;
  assign in_uop.vs1_data_valid = uop_vs1_data_valid;
  assign in_uop.vs2_data       = uop_vs2_data;
  assign in_uop.vs2_data_valid = uop_vs2_data_valid;
  assign in_uop.vs2_eew        = rvv_uop_pkg::eew_e'(uop_vs2_eew);
  assign in_uop.rs1_data       = uop_rs1_data;
  assign in_uop.rs1_data_valid = uop_rs1_data_valid;

  rvv_alu_issue_queue #(
    .queue_depth (queue_depth)
  ) issue_queue_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (uop_valid),
    .in_ready  (uop_ready),
    .in_uop    (in_uop),
    .out_valid (rs_valid),
    .out_ready (rs_ready),
    .out_uop   (rs_uop)
  );

  rvv_pu2rob_if res_if (
    .clk (clk)
  );

  rvv_alu_mask_unit mask_unit_i (
    .rs_valid (rs_valid),
    .rs_uop   (rs_uop),
    .rs_ready (rs_ready),
    .res      (res_if.unit)
  );

  rvv_alu_result_stage result_stage_i (
    .clk       (clk),
    .reset     (reset),
    .res       (res_if.stage),
    .out_valid (result_valid),
    .out_ready (result_ready),
    .out_rec   (out_rec)
  );

  assign result_rob_entry  = out_rec.rob_entry;
  assign result_w_data     = out_rec.w_data;
  assign result_vxsat      = out_rec.vxsat;
  assign result_ignore_vta = out_rec.ignore_vta;
  assign result_ignore_vma = out_rec.ignore_vma;

endmodule

`default_nettype wire

// ==== hdl/rvv_alu_result_stage.sv ====
`default_nettype none

module rvv_alu_result_stage (
  input  logic                 clk,
  input  logic                 reset,
  rvv_pu2rob_if.stage          res,
  output logic                 out_valid,
  input  logic                 out_ready,
  output rvv_uop_pkg::pu2rob_t out_rec
);

  logic                 full;
  rvv_uop_pkg::pu2rob_t rec_q;
  logic                 load;

  // take a new record when empty or when the held one leaves now
  assign res.ready = !full || out_ready;
  assign load      = res.valid && res.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rec_q.rob_entry  <= res.rob_entry;
      rec_q.w_data     <= res.w_data;
      // logic ops never saturate
      rec_q.vxsat      <= 1'b0;
      rec_q.ignore_vta <= res.ignore_vta;
      rec_q.ignore_vma <= res.ignore_vma;
    end
  end

  assign out_valid = full;
  assign out_rec   = rec_q;

  held_record_stable: assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_rec)
  );

endmodule

`default_nettype wire

// ==== hdl/rvv_alu_mask_unit.sv ====
`default_nettype none

module rvv_alu_mask_unit (
  input  logic                 rs_valid,
  input  rvv_uop_pkg::alu_rs_t rs_uop,
  output logic                 rs_ready,
  rvv_pu2rob_if.unit           res
);

  typedef enum logic [3:0] {
    op_none,
    op_vand,
    op_vor,
    op_vxor,
    op_vmandn,
    op_vmand,
    op_vmor,
    op_vmxor,
    op_vmorn,
    op_vmnand,
    op_vmnor,
    op_vmxnor
  } op_e;

  op_e                          op;
  logic                         is_mask;
  logic                         operands_ok;
  logic [rvv_cfg_pkg::vlen-1:0] src1;
  logic [rvv_cfg_pkg::vlen-1:0] src2;
  logic [rvv_cfg_pkg::vlen-1:0] result;
  logic [rvv_cfg_pkg::vlen-1:0] below_vstart;

  // decode
  always_comb begin
    op = op_none;
    case (rs_uop.funct3)
      rvv_uop_pkg::opivv,
      rvv_uop_pkg::opivx,
      rvv_uop_pkg::opivi: begin
        case (rs_uop.funct6)
          rvv_uop_pkg::vand: op = op_vand;
          rvv_uop_pkg::vor:  op = op_vor;
          rvv_uop_pkg::vxor: op = op_vxor;
          default:           op = op_none;
        endcase
      end
      rvv_uop_pkg::opmvv: begin
        case (rs_uop.funct6)
          rvv_uop_pkg::vmandn: op = op_vmandn;
          rvv_uop_pkg::vmand:  op = op_vmand;
          rvv_uop_pkg::vmor:   op = op_vmor;
          rvv_uop_pkg::vmxor:  op = op_vmxor;
          rvv_uop_pkg::vmorn:  op = op_vmorn;
          rvv_uop_pkg::vmnand: op = op_vmnand;
          rvv_uop_pkg::vmnor:  op = op_vmnor;
          rvv_uop_pkg::vmxnor: op = op_vmxnor;
          default:             op = op_none;
        endcase
      end
      default: op = op_none;
    endcase
  end

  assign is_mask = (rs_uop.funct3 == rvv_uop_pkg::opmvv) && (op != op_none);

  // required operands per form
  always_comb begin
    case (rs_uop.funct3)
      rvv_uop_pkg::opivv: operands_ok = rs_uop.vs1_data_valid && rs_uop.vs2_data_valid;
      rvv_uop_pkg::opivx,
      rvv_uop_pkg::opivi: operands_ok = rs_uop.rs1_data_valid && rs_uop.vs2_data_valid;
      rvv_uop_pkg::opmvv: operands_ok = rs_uop.vs1_data_valid && rs_uop.vs2_data_valid &&
                                        rs_uop.vd_data_valid && rs_uop.vm;
      default:            operands_ok = 1'b0;
    endcase
  end

  // scalar forms broadcast rs1 at the element width
  always_comb begin
    src2 = rs_uop.vs2_data;
    src1 = rs_uop.vs1_data;
    if (rs_uop.funct3 == rvv_uop_pkg::opivx || rs_uop.funct3 == rvv_uop_pkg::opivi) begin
      case (rs_uop.vs2_eew)
        rvv_uop_pkg::eew8:
          src1 = {(rvv_cfg_pkg::vlen/rvv_cfg_pkg::byte_width)
                  {rs_uop.rs1_data[rvv_cfg_pkg::byte_width-1:0]}};
        rvv_uop_pkg::eew16:
          src1 = {(rvv_cfg_pkg::vlen/rvv_cfg_pkg::hword_width)
                  {rs_uop.rs1_data[rvv_cfg_pkg::hword_width-1:0]}};
        rvv_uop_pkg::eew32:
          src1 = {(rvv_cfg_pkg::vlen/rvv_cfg_pkg::word_width)
                  {rs_uop.rs1_data[rvv_cfg_pkg::word_width-1:0]}};
        default: src1 = '0;
      endcase
    end
  end

  // vs2 is always the left operand
  always_comb begin
    case (op)
      op_vand, op_vmand: result = src2 & src1;
      op_vor, op_vmor:   result = src2 | src1;
      op_vxor, op_vmxor: result = src2 ^ src1;
      op_vmandn:         result = src2 & ~src1;
      op_vmorn:          result = src2 | ~src1;
      op_vmnand:         result = ~(src2 & src1);
      op_vmnor:          result = ~(src2 | src1);
      op_vmxnor:         result = ~(src2 ^ src1);
      default:           result = '0;
    endcase
  end

  assign below_vstart = (rvv_cfg_pkg::vlen'(1) << rs_uop.vstart) - 1'b1;

  // mask ops keep the old vd bits below vstart
  assign res.w_data = is_mask ? ((rs_uop.vd_data & below_vstart) | (result & ~below_vstart))
                              : result;

  assign res.valid      = rs_valid && (op != op_none) && operands_ok;
  assign res.rob_entry  = rs_uop.rob_entry;
  assign res.ignore_vta = is_mask;
  assign res.ignore_vma = 1'b0;

  // unsupported uops drain at the same rate
  assign rs_ready = res.ready;

  // a stalled result holds until the stage takes it
  result_held_until_ready: assert property (
    @(posedge res.clk) res.valid && !res.ready |=>
      res.valid && $stable(res.rob_entry) && $stable(res.w_data) &&
      $stable(res.ignore_vta)
  );

endmodule

`default_nettype wire

// ==== hdl/rvv_alu_issue_queue.sv ====
`default_nettype none

module rvv_alu_issue_queue #(
  parameter int queue_depth = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  rvv_uop_pkg::alu_rs_t in_uop,
  output logic                 out_valid,
  input  logic                 out_ready,
  output rvv_uop_pkg::alu_rs_t out_uop
);

  localparam int ptr_width = $clog2(queue_depth);
  localparam int cnt_width = $clog2(queue_depth + 1);

  rvv_uop_pkg::alu_rs_t mem [queue_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 push;
  logic                 pop;

  assign in_ready  = (count != cnt_width'(queue_depth));
  assign out_valid = (count != '0);

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // head entry shows up the cycle after it is written
  assign out_uop = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_uop;
    end
  end

  // pointers wrap on their own for power-of-two depths
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  no_overflow: assert property (
    @(posedge clk) disable iff (reset)
    count <= cnt_width'(queue_depth)
  );

  pointers_track_count: assert property (
    @(posedge clk) disable iff (reset)
    ptr_width'(wr_ptr - rd_ptr) == count[ptr_width-1:0]
  );

endmodule

`default_nettype wire

// ==== hdl/rvv_pu2rob_if.sv ====
`default_nettype none

interface rvv_pu2rob_if (
  input logic clk
);

  logic                                    valid;
  logic                                    ready;
  logic [rvv_cfg_pkg::rob_depth_width-1:0] rob_entry;
  logic [rvv_cfg_pkg::vlen-1:0]            w_data;
  logic                                    ignore_vta;
  logic                                    ignore_vma;

  // clk only for checks in the producer
  modport unit (
    input  clk,
    input  ready,
    output valid,
    output rob_entry,
    output w_data,
    output ignore_vta,
    output ignore_vma
  );

  modport stage (
    input  valid,
    input  rob_entry,
    input  w_data,
    input  ignore_vta,
    input  ignore_vma,
    output ready
  );

endinterface

`default_nettype wire

// ==== hdl/rvv_uop_pkg.sv ====
`default_nettype none

package rvv_uop_pkg;

  localparam int funct3_width = 3;
  localparam int funct6_width = 6;

  typedef enum logic [funct3_width-1:0] {
    opivv = 3'b000,
    opmvv = 3'b010,
    opivi = 3'b011,
    opivx = 3'b100
  } funct3_e;

  // integer group used with opivv/opivx/opivi
  typedef enum logic [funct6_width-1:0] {
    vand = 6'b001001,
    vor  = 6'b001010,
    vxor = 6'b001011
  } funct6_ari_e;

  // mask group used with opmvv
  typedef enum logic [funct6_width-1:0] {
    vmandn = 6'b011000,
    vmand  = 6'b011001,
    vmor   = 6'b011010,
    vmxor  = 6'b011011,
    vmorn  = 6'b011100,
    vmnand = 6'b011101,
    vmnor  = 6'b011110,
    vmxnor = 6'b011111
  } funct6_mask_e;

  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  typedef struct packed {
    logic [rvv_cfg_pkg::rob_depth_width-1:0] rob_entry;
    // raw field whose meaning depends on funct3
    logic [funct6_width-1:0]                 funct6;
    funct3_e                                 funct3;
    logic [rvv_cfg_pkg::vstart_width-1:0]    vstart;
    logic                                    vm;
    logic [rvv_cfg_pkg::vlen-1:0]            vd_data;
    logic                                    vd_data_valid;
    logic [rvv_cfg_pkg::vlen-1:0]            vs1_data;
    logic                                    vs1_data_valid;
    logic [rvv_cfg_pkg::vlen-1:0]            vs2_data;
    logic                                    vs2_data_valid;
    eew_e                                    vs2_eew;
    logic [rvv_cfg_pkg::xlen-1:0]            rs1_data;
    logic                                    rs1_data_valid;
  } alu_rs_t;

  typedef struct packed {
    logic [rvv_cfg_pkg::rob_depth_width-1:0] rob_entry;
    logic [rvv_cfg_pkg::vlen-1:0]            w_data;
    logic                                    vxsat;
    logic                                    ignore_vta;
    logic                                    ignore_vma;
  } pu2rob_t;

endpackage

`default_nettype wire

// ==== hdl/rvv_cfg_pkg.sv ====
`default_nettype none

package rvv_cfg_pkg;

  // vector register and scalar widths
  localparam int vlen = 128;
  localparam int xlen = 32;

  localparam int rob_depth_width = 4;

  // wide enough to index every bit of a vector register
  localparam int vstart_width = 7;

  // element sizes
  localparam int byte_width = 8;
  localparam int hword_width = 16;
  localparam int word_width = 32;

endpackage

`default_nettype wire
